// File: hdl/sd_dat_block_ctrl.sv
// -------------------------------------
// SD DAT read transfer controller
// Counts blocks, collects errors, ends
// the transfer and reports its status
// -------------------------------------
`timescale 1ns/10ps

module sd_dat_block_ctrl (
  input  logic                             clk_i,
  input  logic                             reset_i,
  input  logic                             start_i,
  input  sd_dat_pkg::blk_cnt_t             block_count_i,
  input  logic                             block_end_i,
  input  logic                             end_bit_err_i,
  input  logic [sd_dat_pkg::NUM_LANES-1:0] lane_crc_err_i,
  input  logic                             timeout_i,
  output logic                             arm_o,
  output logic                             xfer_active_o,
  output logic                             block_done_o,
  output sd_dat_pkg::dat_status_t          status_o,
  output logic                             status_valid_o
);
  import sd_dat_pkg::*;

  xfer_state_e state_q;
  xfer_state_e state_d;
  blk_cnt_t    remaining_q;
  dat_status_t status_q;
  logic        arm_q;
  logic        block_done_q;
  logic        block_err;

  // Errors of the block just received
  assign block_err = status_q.crc_err || status_q.end_bit_err;

  always_comb begin
    state_d = state_q;
    unique case (state_q)
      READY: begin
        if (start_i) state_d = RECEIVING;
      end
      RECEIVING: begin
        if (timeout_i) begin
          state_d = FINISH;
        end else if (block_end_i) begin
          state_d = BLOCK_DONE;
        end
      end
      BLOCK_DONE: begin
        if (block_err || (remaining_q == '0)) begin
          state_d = FINISH;
        end else begin
          state_d = RECEIVING;
        end
      end
      FINISH: begin
        state_d = READY;
      end
      default: begin
        state_d = READY;
      end
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_q      <= READY;
      remaining_q  <= '0;
      status_q     <= '0;
      arm_q        <= 1'b0;
      block_done_q <= 1'b0;
    end else begin
      state_q      <= state_d;
      block_done_q <= block_end_i;
      // New block begins on every entry to RECEIVING
      arm_q        <= (state_d == RECEIVING) && (state_q != RECEIVING);
      case (state_q)
        READY: begin
          if (start_i) begin
            remaining_q <= block_count_i;
            status_q    <= '0;
          end
        end
        RECEIVING: begin
          if (timeout_i) begin
            status_q.timeout <= 1'b1;
          end else if (block_end_i) begin
            remaining_q          <= remaining_q - 1'b1;
            status_q.crc_err     <= |lane_crc_err_i;
            status_q.end_bit_err <= end_bit_err_i;
          end
        end
        default: ;
      endcase
    end
  end

  assign arm_o          = arm_q;
  assign block_done_o   = block_done_q;
  assign xfer_active_o  = (state_q != READY);
  assign status_o       = status_q;
  assign status_valid_o = (state_q == FINISH);

endmodule

// File: hdl/sd_dat_deser.sv
// -------------------------------------
// SD DAT receive deserializer
// Finds the start bit, walks the data,
// CRC and end phases, packs 32-bit words
// -------------------------------------
`timescale 1ns/10ps

module sd_dat_deser (
  input  logic                   clk_i,
  input  logic                   reset_i,
  input  logic                   sd_clk_en_i,
  input  sd_dat_pkg::nibble_t    dat_i,
  input  logic                   arm_i,
  input  logic                   abort_i,
  input  sd_dat_pkg::blk_size_t  block_size_i,
  output logic                   hunting_o,
  output sd_dat_pkg::lane_ctrl_t lane_ctrl_o,
  output sd_dat_pkg::nibble_t    lane_bits_o,
  output sd_dat_pkg::data_word_t word_o,
  output logic                   word_valid_o,
  output logic                   block_end_o,
  output logic                   end_bit_err_o
);
  import sd_dat_pkg::*;

  deser_phase_e               phase_q;
  deser_phase_e               phase_d;
  logic [BLK_SIZE_W:0]        nib_cnt_q;
  logic [BLK_SIZE_W:0]        nib_last;
  logic [$clog2(CRC_W)-1:0]   crc_cnt_q;
  data_word_t                 word_q;
  logic                       word_valid_q;
  logic                       block_end_q;
  logic                       end_bit_err_q;

  // Two nibbles per byte
  assign nib_last = {block_size_i, 1'b0} - (BLK_SIZE_W+1)'(1);

  always_comb begin
    phase_d = phase_q;
    unique case (phase_q)
      IDLE: begin
        if (arm_i) phase_d = HUNT;
      end
      HUNT: begin
        if (sd_clk_en_i && (dat_i == '0)) phase_d = DATA;
      end
      DATA: begin
        if (sd_clk_en_i && (nib_cnt_q == nib_last)) phase_d = CRC;
      end
      CRC: begin
        if (sd_clk_en_i && (crc_cnt_q == '1)) phase_d = END;
      end
      END: begin
        if (sd_clk_en_i) phase_d = IDLE;
      end
      default: begin
        phase_d = IDLE;
      end
    endcase
    if (abort_i) begin
      phase_d = IDLE;
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      phase_q       <= IDLE;
      nib_cnt_q     <= '0;
      crc_cnt_q     <= '0;
      word_valid_q  <= 1'b0;
      block_end_q   <= 1'b0;
      end_bit_err_q <= 1'b0;
    end else begin
      phase_q      <= phase_d;
      word_valid_q <= 1'b0;
      block_end_q  <= 1'b0;
      if (phase_q == HUNT) begin
        nib_cnt_q <= '0;
        crc_cnt_q <= '0;
      end else if (sd_clk_en_i && !abort_i) begin
        case (phase_q)
          DATA: begin
            nib_cnt_q    <= nib_cnt_q + 1'b1;
            // Eighth nibble completes a word
            word_valid_q <= (nib_cnt_q[2:0] == 3'b111);
          end
          CRC: begin
            crc_cnt_q <= crc_cnt_q + 1'b1;
          end
          END: begin
            block_end_q   <= 1'b1;
            end_bit_err_q <= (dat_i != '1);
          end
          default: ;
        endcase
      end
    end
  end

  // First nibble ends up in the top bits
  always_ff @(posedge clk_i) begin
    if (sd_clk_en_i && (phase_q == DATA)) begin
      word_q <= {word_q[WORD_W-NUM_LANES-1:0], dat_i};
    end
  end

  always_comb begin
    lane_ctrl_o.clear   = (phase_q == HUNT);
    lane_ctrl_o.data_en = (phase_q == DATA);
    lane_ctrl_o.crc_en  = (phase_q == CRC);
  end

  assign hunting_o     = (phase_q == HUNT);
  assign lane_bits_o   = dat_i;
  assign word_o        = word_q;
  assign word_valid_o  = word_valid_q;
  assign block_end_o   = block_end_q;
  assign end_bit_err_o = end_bit_err_q;

endmodule

// File: hdl/sd_dat_lane_crc.sv
// -------------------------------------
// SD DAT lane CRC16 checker
// Serial CRC over one DAT line, then a
// bitwise compare with the received CRC
// -------------------------------------
`timescale 1ns/10ps

module sd_dat_lane_crc (
  input  logic                   clk_i,
  input  logic                   reset_i,
  input  logic                   sd_clk_en_i,
  input  sd_dat_pkg::lane_ctrl_t ctrl_i,
  input  logic                   bit_i,
  output logic                   crc_err_o
);
  import sd_dat_pkg::*;

  logic [CRC_W-1:0] crc_q;
  logic [CRC_W-1:0] crc_shift;
  logic             feedback;
  logic             data_tick;
  logic             crc_tick;
  logic             err_q;

  assign data_tick = sd_clk_en_i && ctrl_i.data_en;
  assign crc_tick  = sd_clk_en_i && ctrl_i.crc_en;

  assign feedback  = crc_q[CRC_W-1] ^ bit_i;
  assign crc_shift = {crc_q[CRC_W-2:0], 1'b0};

  always_ff @(posedge clk_i) begin
    if (ctrl_i.clear) begin
      crc_q <= '0;
    end else if (data_tick) begin
      crc_q <= feedback ? (crc_shift ^ CRC_POLY) : crc_shift;
    end else if (crc_tick) begin
      // Expected CRC leaves MSB first
      crc_q <= crc_shift;
    end
  end

  // Sticky until the next block clears it
  always_ff @(posedge clk_i) begin
    if (reset_i || ctrl_i.clear) begin
      err_q <= 1'b0;
    end else if (crc_tick && (bit_i != crc_q[CRC_W-1])) begin
      err_q <= 1'b1;
    end
  end

  assign crc_err_o = err_q;

endmodule

// File: hdl/sd_dat_pkg.sv
// -------------------------------------
// SD DAT receive path definitions
// Widths, vector types, control structs
// and the state encodings of the path
// -------------------------------------

package sd_dat_pkg;

  localparam int NUM_LANES  = 4;
  localparam int CRC_W      = 16;
  localparam int BLK_SIZE_W = 10;
  localparam int WORD_W     = 32;

  // CRC16 x^16 + x^12 + x^5 + 1
  localparam logic [CRC_W-1:0] CRC_POLY = 16'h1021;

  typedef logic [WORD_W-1:0]     data_word_t;
  typedef logic [NUM_LANES-1:0]  nibble_t;
  typedef logic [BLK_SIZE_W-1:0] blk_size_t;
  typedef logic [15:0]           blk_cnt_t;
  typedef logic [15:0]           tmo_t;

  // Per tick control shared by all lane CRC units
  typedef struct packed {
    logic clear;
    logic data_en;
    logic crc_en;
  } lane_ctrl_t;

  typedef struct packed {
    logic crc_err;
    logic end_bit_err;
    logic timeout;
  } dat_status_t;

  typedef enum logic [2:0] {IDLE, HUNT, DATA, CRC, END} deser_phase_e;

  typedef enum logic [1:0] {READY, RECEIVING, BLOCK_DONE, FINISH} xfer_state_e;

endpackage

// File: hdl/sd_dat_rx_top.sv
// -------------------------------------
// SD DAT 4-bit receive subsystem
// Deserializer, per lane CRC checks,
// start bit timeout and block control
// -------------------------------------
`timescale 1ns/10ps

module sd_dat_rx_top (
  input  logic                    clk_i,
  input  logic                    reset_i,
  input  logic                    sd_clk_en_i,
  input  sd_dat_pkg::nibble_t     dat_i,
  input  logic                    start_i,
  input  sd_dat_pkg::blk_size_t   block_size_i,
  input  sd_dat_pkg::blk_cnt_t    block_count_i,
  input  sd_dat_pkg::tmo_t        timeout_i,
  output sd_dat_pkg::data_word_t  word_o,
  output logic                    word_valid_o,
  output logic                    block_done_o,
  output logic                    xfer_active_o,
  output sd_dat_pkg::dat_status_t status_o,
  output logic                    status_valid_o
);
  import sd_dat_pkg::*;

  lane_ctrl_t           lane_ctrl;
  nibble_t              lane_bits;
  logic [NUM_LANES-1:0] lane_crc_err;
  logic                 arm;
  logic                 hunting;
  logic                 timeout;
  logic                 block_end;
  logic                 end_bit_err;

  sd_dat_deser u_deser (
    .clk_i,
    .reset_i,
    .sd_clk_en_i,
    .dat_i,
    .arm_i         (arm),
    .abort_i       (timeout),
    .block_size_i,
    .hunting_o     (hunting),
    .lane_ctrl_o   (lane_ctrl),
    .lane_bits_o   (lane_bits),
    .word_o,
    .word_valid_o,
    .block_end_o   (block_end),
    .end_bit_err_o (end_bit_err)
  );

  // One CRC16 per DAT line
  for (genvar k = 0; k < NUM_LANES; k++) begin : g_lane
    sd_dat_lane_crc u_lane_crc (
      .clk_i,
      .reset_i,
      .sd_clk_en_i,
      .ctrl_i    (lane_ctrl),
      .bit_i     (lane_bits[k]),
      .crc_err_o (lane_crc_err[k])
    );
  end

  sd_dat_timeout u_timeout (
    .clk_i,
    .reset_i,
    .sd_clk_en_i,
    .run_i     (hunting),
    .limit_i   (timeout_i),
    .timeout_o (timeout)
  );

  sd_dat_block_ctrl u_block_ctrl (
    .clk_i,
    .reset_i,
    .start_i,
    .block_count_i,
    .block_end_i    (block_end),
    .end_bit_err_i  (end_bit_err),
    .lane_crc_err_i (lane_crc_err),
    .timeout_i      (timeout),
    .arm_o          (arm),
    .xfer_active_o,
    .block_done_o,
    .status_o,
    .status_valid_o
  );

endmodule

// File: hdl/sd_dat_timeout.sv
// -------------------------------------
// SD DAT start bit timeout
// Counts card clock ticks during the
// start bit hunt and flags a timeout
// -------------------------------------
`timescale 1ns/10ps

module sd_dat_timeout (
  input  logic             clk_i,
  input  logic             reset_i,
  input  logic             sd_clk_en_i,
  input  logic             run_i,
  input  sd_dat_pkg::tmo_t limit_i,
  output logic             timeout_o
);
  import sd_dat_pkg::*;

  tmo_t cnt_q;
  logic fired_q;
  logic hit;

  // This tick brings the count up to the limit
  assign hit = run_i && sd_clk_en_i && !fired_q && ((cnt_q + tmo_t'(1)) == limit_i);

  always_ff @(posedge clk_i) begin
    if (reset_i || !run_i) begin
      cnt_q     <= '0;
      fired_q   <= 1'b0;
      timeout_o <= 1'b0;
    end else begin
      timeout_o <= hit;
      if (hit) begin
        fired_q <= 1'b1;
      end
      if (sd_clk_en_i) begin
        cnt_q <= cnt_q + tmo_t'(1);
      end
    end
  end

endmodule

// File: project.f
hdl/sd_dat_pkg.sv
hdl/sd_dat_timeout.sv
hdl/sd_dat_lane_crc.sv
hdl/sd_dat_deser.sv
hdl/sd_dat_block_ctrl.sv
hdl/sd_dat_rx_top.sv
tb/sd_dat_rx_asserts.sv
tb/sd_dat_rx_tb.sv

// File: run.sh
#!/bin/sh
# Compile the SD DAT receive testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

TOP=sd_dat_rx_tb
BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
  -f project.f \
  --top-module "$TOP" \
  -Mdir "$BUILD_DIR" \
  -o "$TOP"
status=$?
if [ "$status" -ne 0 ]; then
  echo "Verilator compile failed with status $status"
  exit 1
fi

"./$BUILD_DIR/$TOP" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ "$status" -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "^All checks passed$" "$LOG"; then
  echo "Simulation PASSED"
  exit 0
fi

echo "Simulation FAILED, see $LOG"
exit 1

// File: tb/sd_dat_rx_asserts.sv
// -------------------------------------
// SD DAT receive interface assertions
// Strobe and status rules at the top
// -------------------------------------
`timescale 1ns/10ps

module sd_dat_rx_asserts (
  input logic clk_i,
  input logic reset_i,
  input logic start_i,
  input logic word_valid_i,
  input logic block_done_i,
  input logic xfer_active_i,
  input logic status_valid_i
);

  // Strobes belong to a running transfer
  a_word_in_xfer: assert property (@(posedge clk_i) disable iff (reset_i)
    word_valid_i |-> xfer_active_i)
    else $error("word_valid_o pulsed outside a transfer");

  a_block_in_xfer: assert property (@(posedge clk_i) disable iff (reset_i)
    block_done_i |-> xfer_active_i)
    else $error("block_done_o pulsed outside a transfer");

  a_status_pulse: assert property (@(posedge clk_i) disable iff (reset_i)
    status_valid_i |=> !status_valid_i)
    else $error("status_valid_o held longer than one cycle");

  a_no_start_overlap: assert property (@(posedge clk_i) disable iff (reset_i)
    !(status_valid_i && start_i))
    else $error("start_i overlaps status_valid_o");

endmodule

bind sd_dat_rx_top sd_dat_rx_asserts u_asserts (
  .clk_i          (clk_i),
  .reset_i        (reset_i),
  .start_i        (start_i),
  .word_valid_i   (word_valid_o),
  .block_done_i   (block_done_o),
  .xfer_active_i  (xfer_active_o),
  .status_valid_i (status_valid_o)
);

// File: tb/sd_dat_rx_tb.sv
// -------------------------------------
// SD DAT receive testbench
// Card model plays read blocks from a
// case table, checks words and status
// -------------------------------------
`timescale 1ns/10ps

module sd_dat_rx_tb;
  import sd_dat_pkg::*;

  typedef enum logic [1:0] {CORR_NONE, CORR_CRC, CORR_END} corr_e;

  typedef struct packed {
    blk_size_t   blk_size;
    blk_cnt_t    blk_cnt;
    tmo_t        tmo;
    logic [15:0] idle;
    corr_e       corr;
    logic [1:0]  corr_lane;
    blk_cnt_t    corr_blk;
    dat_status_t exp_status;
  } case_row_t;

  localparam int NUM_CASES   = 7;
  localparam int STATUS_WAIT = 20000;
  localparam int TICK_WAIT   = 8;

  logic        clk;
  logic        reset;
  logic        sd_clk_en;
  nibble_t     dat;
  logic        start;
  blk_size_t   block_size;
  blk_cnt_t    block_count;
  tmo_t        timeout;
  data_word_t  word;
  logic        word_valid;
  logic        block_done;
  logic        xfer_active;
  dat_status_t status;
  logic        status_valid;

  case_row_t   cases [NUM_CASES];
  data_word_t  exp_words [$];
  logic [15:0] lfsr;
  logic        hung;
  int          errors;
  int          checks;
  int          word_cnt;
  int          done_cnt;

  sd_dat_rx_top u_dut (
    .clk_i          (clk),
    .reset_i        (reset),
    .sd_clk_en_i    (sd_clk_en),
    .dat_i          (dat),
    .start_i        (start),
    .block_size_i   (block_size),
    .block_count_i  (block_count),
    .timeout_i      (timeout),
    .word_o         (word),
    .word_valid_o   (word_valid),
    .block_done_o   (block_done),
    .xfer_active_o  (xfer_active),
    .status_o       (status),
    .status_valid_o (status_valid)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // Card clock rising edge every fourth cycle
  initial begin : tick_gen
    logic [1:0] div;
    div       = 2'd0;
    sd_clk_en = 1'b0;
    forever begin
      @(posedge clk);
      #1;
      div       = div + 2'd1;
      sd_clk_en = (div == 2'd0);
    end
  end

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("ERROR %s: got 0x%h, expected 0x%h", name, got, exp);
    end
  endtask

  // Fibonacci LFSR with taps 16 14 13 11
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  task automatic take_byte(output logic [7:0] b);
    b = '0;
    for (int i = 0; i < 8; i++) begin
      lfsr = lfsr_next(lfsr);
      b    = {b[6:0], lfsr[0]};
    end
  endtask

  // Serial CRC16 over x^16 + x^12 + x^5 + 1
  function automatic logic [15:0] crc16_bit(input logic [15:0] crc, input logic b);
    logic [15:0] shifted;
    shifted = {crc[14:0], 1'b0};
    return (crc[15] ^ b) ? (shifted ^ 16'h1021) : shifted;
  endfunction

  task automatic wait_tick();
    int n;
    n = 0;
    do begin
      @(posedge clk);
      n++;
    end while (!sd_clk_en && n < TICK_WAIT);
    if (!sd_clk_en) begin
      $display("Card clock tick did not arrive within %0d cycles", TICK_WAIT);
      errors++;
      hung = 1'b1;
    end
  endtask

  // Value is stable at the following tick
  task automatic send_nibble(input nibble_t v);
    wait_tick();
    #1;
    dat = v;
  endtask

  task automatic play_card(input case_row_t row);
    logic [15:0] crc [NUM_LANES];
    logic [7:0]  b;
    data_word_t  w;
    nibble_t     nib;
    int          nblk;
    w    = '0;
    nblk = (row.corr == CORR_NONE) ? int'(row.blk_cnt) : int'(row.corr_blk);
    for (int blk = 1; blk <= nblk; blk++) begin
      for (int i = 0; i < int'(row.idle); i++) begin
        send_nibble(4'hf);
      end
      // Card never answers within the limit
      if (row.idle >= row.tmo) begin
        break;
      end
      send_nibble(4'h0);
      for (int k = 0; k < NUM_LANES; k++) begin
        crc[k] = '0;
      end
      for (int n = 0; n < int'(row.blk_size); n++) begin
        take_byte(b);
        w = {w[23:0], b};
        if (n % 4 == 3) begin
          exp_words.push_back(w);
        end
        for (int h = 0; h < 2; h++) begin
          nib = (h == 0) ? b[7:4] : b[3:0];
          for (int k = 0; k < NUM_LANES; k++) begin
            crc[k] = crc16_bit(crc[k], nib[k]);
          end
          send_nibble(nib);
        end
      end
      if (row.corr == CORR_CRC && blk == nblk) begin
        crc[row.corr_lane][5] = ~crc[row.corr_lane][5];
      end
      for (int j = 15; j >= 0; j--) begin
        for (int k = 0; k < NUM_LANES; k++) begin
          nib[k] = crc[k][j];
        end
        send_nibble(nib);
      end
      nib = 4'hf;
      if (row.corr == CORR_END && blk == nblk) begin
        nib[row.corr_lane] = 1'b0;
      end
      send_nibble(nib);
    end
    send_nibble(4'hf);
  endtask

  task automatic collect_transfer(input case_row_t row);
    data_word_t exp_w;
    int         n;
    n = 0;
    while (!status_valid && n < STATUS_WAIT) begin
      @(negedge clk);
      n++;
      if (word_valid) begin
        word_cnt++;
        if (exp_words.size() == 0) begin
          $display("Word 0x%h arrived when no word was expected", word);
          errors++;
        end else begin
          exp_w = exp_words.pop_front();
          check_value("word_o", word, exp_w);
        end
      end
      if (block_done) begin
        done_cnt++;
      end
    end
    if (!status_valid) begin
      $display("Transfer status did not arrive within %0d cycles", STATUS_WAIT);
      errors++;
      hung = 1'b1;
    end else begin
      check_value("status_o", {29'd0, status}, {29'd0, row.exp_status});
      @(negedge clk);
      check_value("xfer_active_o", {31'd0, xfer_active}, 32'd0);
    end
  endtask

  task automatic check_idle(input int cycles);
    repeat (cycles) begin
      @(negedge clk);
      check_value("xfer_active_o", {31'd0, xfer_active}, 32'd0);
      check_value("word_valid_o", {31'd0, word_valid}, 32'd0);
      check_value("block_done_o", {31'd0, block_done}, 32'd0);
      check_value("status_valid_o", {31'd0, status_valid}, 32'd0);
    end
  endtask

  task automatic run_case(input case_row_t row);
    int exp_blocks;
    if (row.idle >= row.tmo) begin
      exp_blocks = 0;
    end else if (row.corr != CORR_NONE) begin
      exp_blocks = int'(row.corr_blk);
    end else begin
      exp_blocks = int'(row.blk_cnt);
    end
    exp_words.delete();
    word_cnt = 0;
    done_cnt = 0;
    wait_tick();
    #1;
    block_size  = row.blk_size;
    block_count = row.blk_cnt;
    timeout     = row.tmo;
    start       = 1'b1;
    @(posedge clk);
    #1;
    start = 1'b0;
    fork
      play_card(row);
      collect_transfer(row);
    join
    check_value("block_done_o count", done_cnt, exp_blocks);
    check_value("word_valid_o count", word_cnt, exp_blocks * int'(row.blk_size) / 4);
  endtask

  initial begin
    errors      = 0;
    checks      = 0;
    hung        = 1'b0;
    lfsr        = 16'd91;
    reset       = 1'b1;
    dat         = 4'hf;
    start       = 1'b0;
    block_size  = '0;
    block_count = '0;
    timeout     = '0;
    // size, count, timeout, idle ticks, corruption, lane, block, status
    cases[0] = '{10'd16, 16'd3, 16'd200, 16'd2, CORR_NONE, 2'd0, 16'd0, 3'b000};
    cases[1] = '{10'd8, 16'd4, 16'd200, 16'd1, CORR_CRC, 2'd2, 16'd2, 3'b100};
    cases[2] = '{10'd12, 16'd3, 16'd200, 16'd0, CORR_END, 2'd1, 16'd1, 3'b010};
    cases[3] = '{10'd8, 16'd2, 16'd20, 16'd40, CORR_NONE, 2'd0, 16'd0, 3'b001};
    cases[4] = '{10'd4, 16'd2, 16'd30, 16'd25, CORR_NONE, 2'd0, 16'd0, 3'b000};
    cases[5] = '{10'd20, 16'd3, 16'd100, 16'd5, CORR_CRC, 2'd0, 16'd2, 3'b100};
    cases[6] = '{10'd8, 16'd2, 16'd100, 16'd3, CORR_CRC, 2'd3, 16'd2, 3'b100};
    repeat (16) @(posedge clk);
    #1;
    reset = 1'b0;
    check_idle(24);
    for (int c = 0; c < NUM_CASES; c++) begin
      if (hung) begin
        break;
      end
      run_case(cases[c]);
    end
    $display("Checks run: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule
